// File: sources.f
+incdir+include
hw/renamePkg.sv
hw/resultForward.sv
hw/regfileLine.sv
hw/checkpointCtrl.sv
hw/regfileRename.sv
testbench/regfileRename_assert.sv
testbench/regfileRename_checker.sv
testbench/regfileRename_tb.sv

// File: Bender.yml
package:
  name: regfile_rename

export_include_dirs:
  - include

sources:
  - hw/renamePkg.sv
  - hw/resultForward.sv
  - hw/regfileLine.sv
  - hw/checkpointCtrl.sv
  - hw/regfileRename.sv
  - target: test
    files:
      - testbench/regfileRename_assert.sv
      - testbench/regfileRename_checker.sv
      - testbench/regfileRename_tb.sv

// File: testbench/regfileRename_tb.sv
`timescale 1ns/1ps
`include "rename_settings.svh"

module regfileRename_tb import renamePkg::*; ();

  localparam int numCycles = 3000;
  localparam int waitLimit = 40;
  localparam int tagCount  = 1 << `RF_TAG_WIDTH;

  logic        clk = 1'b0;
  logic        rst;
  resultBusT   aluResult;
  resultBusT   lsResult;
  regNameT     readNameA;
  regNameT     readNameB;
  slotT        readA;
  slotT        readB;
  logic        renameEn;
  regNameT     renameName;
  tagT         renameTag;
  logic        branchPush;
  logic        branchFree;
  logic        branchMispredict;
  logic        checkpointFull;
  logic        checkpointEmpty;
  logic [31:0] lcgState;
  // tags renamed and not yet broadcast
  logic        pendingTags [tagCount];
  int          cycleCount;
  int          timeoutErrors;

  bind regfileRename regfileRename_assert u_assert (.*);

  regfileRename u_regfileRename (.*);

  regfileRename_checker u_checker (.*);

  initial begin
    forever #5 clk = ~clk;
  end

  function automatic logic [31:0] nextRandom();
    lcgState = lcgState * 32'd1664525 + 32'd1013904223;
    return lcgState;
  endfunction

  // upper bits of the LCG are the better ones
  function automatic int randBelow(input int limit);
    return int'(nextRandom() >> 16) % limit;
  endfunction

  // sometimes broadcast a pending tag, which then leaves the list
  function automatic resultBusT randomBroadcast();
    resultBusT bus;
    int        idx;
    int        start;
    bus   = busIdle;
    start = randBelow(tagCount);
    for (int k = 0; k < tagCount; k++) begin
      idx = (start + k) % tagCount;
      if (!bus.valid && idx != `RF_TAG_FREE && pendingTags[idx] && randBelow(3) != 0) begin
        bus.valid        = 1'b1;
        bus.tag          = tagT'(idx);
        bus.data         = nextRandom();
        pendingTags[idx] = 1'b0;
      end
    end
    return bus;
  endfunction

  // an idle bus now and then carries the free tag, which must leave every slot alone
  function automatic resultBusT freeTagBroadcast(input resultBusT bus);
    resultBusT r;
    r = bus;
    if (!bus.valid && randBelow(8) == 0) begin
      r.valid = 1'b1;
      r.tag   = tagT'(`RF_TAG_FREE);
      r.data  = nextRandom();
    end
    return r;
  endfunction

  // one clock of random traffic with a branch strobe
  // kind 0 none, 1 push, 2 free, 3 mispredict
  task automatic runCycle(input int kind);
    tagT       newTag;
    resultBusT aluBus;
    resultBusT lsBus;
    @(posedge clk);
    readNameA <= regNameT'(randBelow(`RF_NUM_REGS));
    readNameB <= regNameT'(randBelow(`RF_NUM_REGS));
    aluBus = randomBroadcast();
    lsBus  = randomBroadcast();
    if (randBelow(2) == 0) begin
      aluBus = freeTagBroadcast(aluBus);
    end else begin
      lsBus = freeTagBroadcast(lsBus);
    end
    aluResult <= aluBus;
    lsResult  <= lsBus;
    if (kind != 1 && randBelow(4) != 0) begin
      newTag = tagT'(1 + randBelow(tagCount - 1));
      renameEn    <= 1'b1;
      renameName  <= regNameT'(randBelow(`RF_NUM_REGS));
      renameTag   <= newTag;
      pendingTags[newTag] = 1'b1;
    end else begin
      renameEn <= 1'b0;
    end
    branchPush       <= (kind == 1);
    branchFree       <= (kind == 2);
    branchMispredict <= (kind == 3);
    cycleCount++;
  endtask

  task automatic branchAfterTraffic(input int kind, input int idleCycles);
    repeat (idleCycles) runCycle(0);
    runCycle(kind);
  endtask

  task automatic waitForFlag(input logic wantFull);
    for (int waited = 0; waited < waitLimit; waited++) begin
      @(negedge clk);
      if ((wantFull ? checkpointFull : checkpointEmpty) === 1'b1) begin
        return;
      end
      runCycle(0);
    end
    timeoutErrors++;
    $display("timeout at %0t: checkpoint %s flag never went high", $time,
             wantFull ? "full" : "empty");
  endtask

  initial begin
    int kind;
    int lastKind;
    int pick;
    int totalErrors;
    lcgState         = 32'h312d_2e73;
    cycleCount       = 0;
    timeoutErrors    = 0;
    rst              = 1'b1;
    aluResult        = busIdle;
    lsResult         = busIdle;
    readNameA        = '0;
    readNameB        = '0;
    renameEn         = 1'b0;
    renameName       = '0;
    renameTag        = '0;
    branchPush       = 1'b0;
    branchFree       = 1'b0;
    branchMispredict = 1'b0;
    for (int t = 0; t < tagCount; t++) begin
      pendingTags[t] = 1'b0;
    end
    repeat (16) @(posedge clk);
    rst <= 1'b0;
    // every register on both ports straight after reset
    for (int r = 0; r < `RF_NUM_REGS; r++) begin
      @(posedge clk);
      readNameA <= regNameT'(r);
      readNameB <= regNameT'(`RF_NUM_REGS - 1 - r);
    end
    // fill the ring, then commit the checkpoints one by one
    repeat (`RF_CKPT_DEPTH - 1) branchAfterTraffic(1, 4);
    waitForFlag(1'b1);
    repeat (`RF_CKPT_DEPTH - 1) branchAfterTraffic(2, 4);
    waitForFlag(1'b0);
    // a free moves the committed slot, the mispredict keeps it
    branchAfterTraffic(1, 1);
    branchAfterTraffic(1, 5);
    branchAfterTraffic(2, 5);
    branchAfterTraffic(3, 5);
    // flags lag a strobe by one cycle, so branches are never back to back
    lastKind = 3;
    while (cycleCount < numCycles) begin
      @(negedge clk);
      kind = 0;
      pick = randBelow(16);
      if (lastKind == 0) begin
        if (pick < 3 && !checkpointFull) begin
          kind = 1;
        end else if (pick < 5 && !checkpointEmpty) begin
          kind = 2;
        end else if (pick == 5) begin
          kind = 3;
        end
      end
      runCycle(kind);
      lastKind = kind;
    end
    @(negedge clk);
    totalErrors = u_checker.readErrors + u_checker.flagErrors + timeoutErrors
                + u_regfileRename.u_assert.failCount;
    $display("errors: read %0d, flag %0d, protocol %0d, timeout %0d",
             u_checker.readErrors, u_checker.flagErrors,
             u_regfileRename.u_assert.failCount, timeoutErrors);
    if (totalErrors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

// File: testbench/regfileRename_checker.sv
`timescale 1ns/1ps
`include "rename_settings.svh"

module regfileRename_checker import renamePkg::*; (
  input logic      clk,
  input logic      rst,
  input resultBusT aluResult,
  input resultBusT lsResult,
  input regNameT   readNameA,
  input regNameT   readNameB,
  input logic      renameEn,
  input regNameT   renameName,
  input tagT       renameTag,
  input logic      branchPush,
  input logic      branchFree,
  input logic      branchMispredict,
  input slotT      readA,
  input slotT      readB,
  input logic      checkpointFull,
  input logic      checkpointEmpty
);

  int      readErrors = 0;
  int      flagErrors = 0;
  // model rings, head is the committed slot and tail the newest one
  slotT    ring [`RF_NUM_REGS][`RF_CKPT_DEPTH];
  slotT    nextRing [`RF_NUM_REGS][`RF_CKPT_DEPTH];
  slotIdxT head;
  slotIdxT tail;
  slotIdxT count;

  // a pending slot takes the data of a bus carrying its tag, ALU bus first
  function automatic slotT resolve(input slotT s, input resultBusT alu, input resultBusT ls);
    slotT r;
    r = s;
    if (s.tag != tagT'(`RF_TAG_FREE)) begin
      if (alu.valid && alu.tag == s.tag) begin
        r.tag  = tagT'(`RF_TAG_FREE);
        r.data = alu.data;
      end else if (ls.valid && ls.tag == s.tag) begin
        r.tag  = tagT'(`RF_TAG_FREE);
        r.data = ls.data;
      end
    end
    return r;
  endfunction

  function automatic slotT expectedRead(input regNameT name);
    if (name == '0) begin
      return slotFree;
    end
    return resolve(ring[name][tail], aluResult, lsResult);
  endfunction

  // data under a pending tag carries no meaning
  task automatic compareRead(input string port, input slotT got, input slotT exp);
    if (got.tag !== exp.tag || (exp.tag == tagT'(`RF_TAG_FREE) && got.data !== exp.data)) begin
      readErrors++;
      $display("MISMATCH at %0t: %s got tag %0h data %h, expected tag %0h data %h",
               $time, port, got.tag, got.data, exp.tag, exp.data);
    end
  endtask

  task automatic compareFlag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      flagErrors++;
      $display("MISMATCH at %0t: %s got %b, expected %b", $time, name, got, exp);
    end
  endtask

  // inputs are stable at the falling edge, so compare and step the model there
  always @(negedge clk) begin
    if (rst) begin
      for (int r = 0; r < `RF_NUM_REGS; r++) begin
        for (int s = 0; s < `RF_CKPT_DEPTH; s++) begin
          ring[r][s] = slotFree;
        end
      end
      head = '0;
      tail = '0;
    end else begin
      count = tail - head;
      compareRead("readA", readA, expectedRead(readNameA));
      compareRead("readB", readB, expectedRead(readNameB));
      compareFlag("checkpointFull", checkpointFull, count == slotIdxT'(`RF_CKPT_DEPTH - 1));
      compareFlag("checkpointEmpty", checkpointEmpty, count == '0);
      // state after the coming rising edge
      for (int r = 0; r < `RF_NUM_REGS; r++) begin
        for (int s = 0; s < `RF_CKPT_DEPTH; s++) begin
          nextRing[r][s] = resolve(ring[r][s], aluResult, lsResult);
        end
        if (branchPush) begin
          nextRing[r][tail + slotIdxT'(1)] = resolve(ring[r][tail], aluResult, lsResult);
        end
      end
      if (renameEn && renameName != '0) begin
        nextRing[renameName][tail].tag = renameTag;
      end
      ring = nextRing;
      if (branchMispredict) begin
        tail = head;
      end else begin
        if (branchPush) begin
          tail = tail + slotIdxT'(1);
        end
        if (branchFree) begin
          head = head + slotIdxT'(1);
        end
      end
    end
  end

endmodule

// File: testbench/regfileRename_assert.sv
`timescale 1ns/1ps

module regfileRename_assert (
  input logic clk,
  input logic rst,
  input logic renameEn,
  input logic branchPush,
  input logic branchFree,
  input logic branchMispredict,
  input logic checkpointFull,
  input logic checkpointEmpty
);

  int failCount = 0;

  // ring holds at most three unresolved branches
  pushNotFull: assert property (@(posedge clk) disable iff (rst) branchPush |-> !checkpointFull)
    else begin
      failCount++;
      $error("branch push while the checkpoint ring is full");
    end

  freeNotEmpty: assert property (@(posedge clk) disable iff (rst) branchFree |-> !checkpointEmpty)
    else begin
      failCount++;
      $error("branch free while no branch is unresolved");
    end

  freeOrMispredict: assert property (@(posedge clk) disable iff (rst)
    !(branchFree && branchMispredict))
    else begin
      failCount++;
      $error("branch free and mispredict in the same cycle");
    end

  // a branch instruction renames nothing
  renameOrPush: assert property (@(posedge clk) disable iff (rst) !(renameEn && branchPush))
    else begin
      failCount++;
      $error("rename and branch push in the same cycle");
    end

endmodule

// File: hw/regfileRename.sv
`timescale 1ns/1ps
`include "rename_settings.svh"

module regfileRename import renamePkg::*; (
  input  logic      clk,
  input  logic      rst,

  // result broadcasts
  input  resultBusT aluResult,
  input  resultBusT lsResult,

  // read ports
  input  regNameT   readNameA,
  input  regNameT   readNameB,
  output slotT      readA,
  output slotT      readB,

  // rename from dispatch
  input  logic      renameEn,
  input  regNameT   renameName,
  input  tagT       renameTag,

  // branch checkpoints
  input  logic      branchPush,
  input  logic      branchFree,
  input  logic      branchMispredict,
  output logic      checkpointFull,
  output logic      checkpointEmpty
);

  slotIdxT ckptTail;
  slotT    lineOut [`RF_NUM_REGS];

  // shared pointers for all lines
  // head only matters inside the controller, the lines follow the tail
  checkpointCtrl u_checkpointCtrl (
    .clk              (clk),
    .rst              (rst),
    .branchPush       (branchPush),
    .branchFree       (branchFree),
    .branchMispredict (branchMispredict),
    .head             (),
    .tail             (ckptTail),
    .checkpointFull   (checkpointFull),
    .checkpointEmpty  (checkpointEmpty)
  );

  // register 0 is hardwired, it has no storage and ignores renames
  assign lineOut[0] = slotFree;

  for (genvar r = 1; r < `RF_NUM_REGS; r++) begin : gLine
    logic lineRename;

    // one-hot rename decode
    assign lineRename = renameEn && (renameName == regNameT'(r));

    regfileLine u_regfileLine (
      .clk       (clk),
      .rst       (rst),
      .aluResult (aluResult),
      .lsResult  (lsResult),
      .renameEn  (lineRename),
      .renameTag (renameTag),
      .tail      (ckptTail),
      .copyEn    (branchPush),
      .current   (lineOut[r])
    );
  end

  // combinational reads, forwarding already done inside each line
  assign readA = lineOut[readNameA];
  assign readB = lineOut[readNameB];

endmodule

// File: hw/checkpointCtrl.sv
`timescale 1ns/1ps
`include "rename_settings.svh"

module checkpointCtrl import renamePkg::*; (
  input  logic    clk,
  input  logic    rst,
  input  logic    branchPush,
  input  logic    branchFree,
  input  logic    branchMispredict,
  output slotIdxT head,
  output slotIdxT tail,
  output logic    checkpointFull,
  output logic    checkpointEmpty
);

  // number of unresolved branches, always tail minus head
  slotIdxT count;

  always_ff @(posedge clk) begin
    if (rst) begin
      head  <= '0;
      tail  <= '0;
      count <= '0;
    end else if (branchMispredict) begin
      // drop every speculative checkpoint, head slot is already up to date
      tail  <= head;
      count <= '0;
    end else begin
      if (branchPush) begin
        tail <= tail + slotIdxT'(1);
      end
      // oldest branch was right, its checkpoint becomes committed
      if (branchFree) begin
        head <= head + slotIdxT'(1);
      end
      case ({branchPush, branchFree})
        2'b10:   count <= count + slotIdxT'(1);
        2'b01:   count <= count - slotIdxT'(1);
        default: count <= count;
      endcase
    end
  end

  // one slot always stays as the committed copy
  assign checkpointFull  = (count == slotIdxT'(`RF_CKPT_DEPTH - 1));
  assign checkpointEmpty = (count == '0);

endmodule

// File: hw/regfileLine.sv
`timescale 1ns/1ps
`include "rename_settings.svh"

module regfileLine import renamePkg::*; (
  input  logic      clk,
  input  logic      rst,
  input  resultBusT aluResult,
  input  resultBusT lsResult,
  input  logic      renameEn,
  input  tagT       renameTag,
  input  slotIdxT   tail,
  input  logic      copyEn,
  output slotT      current
);

  // checkpoint ring of this register
  // head slot is the committed value, tail slot the newest speculative one
  slotT    slots [`RF_CKPT_DEPTH];
  slotT    fwdSlots [`RF_CKPT_DEPTH];
  slotIdxT nextTail;

  assign nextTail = tail + slotIdxT'(1);

  // every slot watches both buses, so older checkpoints stay current too
  for (genvar s = 0; s < `RF_CKPT_DEPTH; s++) begin : gSlot
    resultForward u_resultForward (
      .current   (slots[s]),
      .aluResult (aluResult),
      .lsResult  (lsResult),
      .forwarded (fwdSlots[s])
    );
  end

  // read sees same-cycle broadcasts
  assign current = fwdSlots[tail];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int s = 0; s < `RF_CKPT_DEPTH; s++) begin
        slots[s] <= slotFree;
      end
    end else begin
      for (int s = 0; s < `RF_CKPT_DEPTH; s++) begin
        slots[s] <= fwdSlots[s];
        // rename replaces only the tag, old data is kept but no longer meaningful
        if (renameEn && (slotIdxT'(s) == tail)) begin
          slots[s].tag <= renameTag;
        end
      end
      // new branch: snapshot the tail into the next slot
      // rename never comes with a push, so the tail slot needs no rename merge here
      if (copyEn) begin
        slots[nextTail] <= fwdSlots[tail];
      end
    end
  end

endmodule

// File: hw/resultForward.sv
`timescale 1ns/1ps
`include "rename_settings.svh"

module resultForward import renamePkg::*; (
  input  slotT      current,
  input  resultBusT aluResult,
  input  resultBusT lsResult,
  output slotT      forwarded
);

  logic slotPending;
  logic aluHit;
  logic lsHit;

  // a free slot already holds its value, no broadcast may touch it
  assign slotPending = (current.tag != tagT'(`RF_TAG_FREE));

  // tag compare against each bus
  assign aluHit = slotPending && aluResult.valid && (aluResult.tag == current.tag);
  assign lsHit  = slotPending && lsResult.valid && (lsResult.tag == current.tag);

  // ALU bus has priority if both claim the slot
  always_comb begin
    forwarded = current;
    if (aluHit) begin
      forwarded.tag  = tagT'(`RF_TAG_FREE);
      forwarded.data = aluResult.data;
    end else if (lsHit) begin
      forwarded.tag  = tagT'(`RF_TAG_FREE);
      forwarded.data = lsResult.data;
    end
  end

endmodule

// File: hw/renamePkg.sv
`include "rename_settings.svh"

package renamePkg;

  // plain vectors with a meaning of their own
  typedef logic [`RF_DATA_WIDTH-1:0] dataT;
  typedef logic [`RF_TAG_WIDTH-1:0]  tagT;
  typedef logic [`RF_NAME_WIDTH-1:0] regNameT;
  typedef logic [`RF_SLOT_WIDTH-1:0] slotIdxT;

  // contents of one checkpoint slot, also what a read port returns
  // tag is the pending producer, or the free tag once data is valid
  typedef struct packed {
    tagT  tag;
    dataT data;
  } slotT;

  // one broadcast result bus
  typedef struct packed {
    logic valid;
    tagT  tag;
    dataT data;
  } resultBusT;

  // reset value of every slot and the fixed contents of register 0
  localparam slotT slotFree = '{
    tag:  tagT'(`RF_TAG_FREE),
    data: '0
  };

  // idle bus, handy for default drive
  localparam resultBusT busIdle = '{
    valid: 1'b0,
    tag:   tagT'(`RF_TAG_FREE),
    data:  '0
  };

endpackage

// File: include/rename_settings.svh
`ifndef RENAME_SETTINGS_SVH
`define RENAME_SETTINGS_SVH

// register value width
`define RF_DATA_WIDTH 32

// reorder-buffer tag width
`define RF_TAG_WIDTH 4

// architectural register file size and name width
`define RF_NUM_REGS 32
`define RF_NAME_WIDTH 5

// checkpoint slots per register, a power of two so the pointers wrap by themselves
`define RF_CKPT_DEPTH 4
`define RF_SLOT_WIDTH 2

// tag value of a slot whose value is present
`define RF_TAG_FREE 0

`endif
